// ==== hw/tinker_consts.svh ====
`ifndef TINKER_CONSTS_SVH
`define TINKER_CONSTS_SVH

// datapath widths
`define TINKER_XLEN      64
`define TINKER_ILEN      32
`define TINKER_NREGS     32
`define TINKER_RIDX_W    5
`define TINKER_LIT_W     12

// instruction fields: opcode 31:27, rd 26:22, rs 21:17, rt 16:12, L 11:0
`define TINKER_OP_MSB    31
`define TINKER_RD_MSB    26
`define TINKER_RS_MSB    21
`define TINKER_RT_MSB    16

// unified byte memory, control register sits just above it
`define TINKER_MEM_BYTES 4096
`define TINKER_PC_RESET  32'h0000_0100
`define TINKER_CTRL_ADDR 32'h0000_1000

// mov r0, r0 (opcode 0x11, all fields zero)
`define TINKER_NOP_WORD  32'h8800_0000

`endif

// ==== hw/tinker_pkg.sv ====
`default_nettype none

`include "tinker_consts.svh"

package tinker_pkg;

    typedef enum logic [4:0] {
        op_and    = 5'h00,
        op_or     = 5'h01,
        op_xor    = 5'h02,
        op_not    = 5'h03,
        op_shftr  = 5'h04,
        op_shftri = 5'h05,
        op_shftl  = 5'h06,
        op_shftli = 5'h07,
        op_br     = 5'h08,  // pc = rd
        op_brr_rd = 5'h09,  // pc += rd
        op_brr_l  = 5'h0a,  // pc += sext(L)
        op_brnz   = 5'h0b,
        op_brgt   = 5'h0e,
        op_halt   = 5'h0f,
        op_load   = 5'h10,  // mov rd, (rs)(L)
        op_mov    = 5'h11,
        op_movl   = 5'h12,  // mov rd, L
        op_store  = 5'h13,  // mov (rd)(L), rs
        op_add    = 5'h18,
        op_addi   = 5'h19,
        op_sub    = 5'h1a,
        op_subi   = 5'h1b
    } opcode_e;

    typedef struct packed {
        logic reg_write;
        logic mem_read;
        logic mem_write;
        logic is_branch;  // real branches only, halt is separate
        logic halt;
    } ctrl_t;

    typedef struct packed {
        ctrl_t                     ctrl;
        opcode_e                   opcode;
        logic [`TINKER_RIDX_W-1:0] rd;
        logic [`TINKER_RIDX_W-1:0] rs;
        logic [`TINKER_RIDX_W-1:0] rt;
        logic [`TINKER_LIT_W-1:0]  lit;
        logic [`TINKER_XLEN-1:0]   rd_val;
        logic [`TINKER_XLEN-1:0]   rs_val;
        logic [`TINKER_XLEN-1:0]   rt_val;
    } idex_t;

    typedef struct packed {
        ctrl_t                     ctrl;
        logic [`TINKER_XLEN-1:0]   alu_result;  // also the load/store address
        logic [`TINKER_XLEN-1:0]   store_data;
        logic [`TINKER_RIDX_W-1:0] rd;
    } exmem_t;

    typedef struct packed {
        ctrl_t                     ctrl;
        logic [`TINKER_XLEN-1:0]   wb_data;  // load data or alu result, already picked
        logic [`TINKER_RIDX_W-1:0] rd;
    } memwb_t;

    typedef enum logic [1:0] {
        from_regfile,
        from_exmem,
        from_memwb
    } fwd_sel_e;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

// ==== hw/tinker_alu.sv ====
`default_nettype none

`include "tinker_consts.svh"

module tinker_alu import tinker_pkg::*; (
    input  wire opcode_e                  opcode,
    input  wire logic [`TINKER_XLEN-1:0]  rd_val,
    input  wire logic [`TINKER_XLEN-1:0]  rs_val,
    input  wire logic [`TINKER_XLEN-1:0]  rt_val,
    input  wire logic [`TINKER_LIT_W-1:0] lit,
    output logic [`TINKER_XLEN-1:0]       result
);
    logic [`TINKER_XLEN-1:0] lit_zx;  // addi/subi
    logic [`TINKER_XLEN-1:0] lit_sx;  // memory offsets

    assign lit_zx = {{(`TINKER_XLEN-`TINKER_LIT_W){1'b0}}, lit};
    assign lit_sx = {{(`TINKER_XLEN-`TINKER_LIT_W){lit[`TINKER_LIT_W-1]}}, lit};

    always_comb begin
        case (opcode)
            op_add:    result = rs_val + rt_val;
            op_addi:   result = rd_val + lit_zx;
            op_sub:    result = rs_val - rt_val;
            op_subi:   result = rd_val - lit_zx;
            op_and:    result = rs_val & rt_val;
            op_or:     result = rs_val | rt_val;
            op_xor:    result = rs_val ^ rt_val;
            op_not:    result = ~rs_val;               // rt ignored
            op_shftr:  result = rs_val >> rt_val[5:0];  // low 6 bits only
            op_shftri: result = rd_val >> lit[5:0];
            op_shftl:  result = rs_val << rt_val[5:0];
            op_shftli: result = rd_val << lit[5:0];
            op_mov:    result = rs_val;
            op_movl:   result = {rd_val[`TINKER_XLEN-1:`TINKER_LIT_W], lit};
            op_load:   result = rs_val + lit_sx;       // address
            op_store:  result = rd_val + lit_sx;       // address
            default:   result = '0;                    // branches, halt, dropped ops
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/tinker_regfile.sv ====
`default_nettype none

`include "tinker_consts.svh"

module tinker_regfile (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire logic [`TINKER_RIDX_W-1:0] rd_idx,
    input  wire logic [`TINKER_RIDX_W-1:0] rs_idx,
    input  wire logic [`TINKER_RIDX_W-1:0] rt_idx,
    output logic [`TINKER_XLEN-1:0]        rd_val,
    output logic [`TINKER_XLEN-1:0]        rs_val,
    output logic [`TINKER_XLEN-1:0]        rt_val,
    input  wire logic                      wr_en,
    input  wire logic [`TINKER_RIDX_W-1:0] wr_idx,
    input  wire logic [`TINKER_XLEN-1:0]   wr_data
);
    logic [`TINKER_XLEN-1:0] regs [`TINKER_NREGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TINKER_NREGS; i++)
                regs[i] <= '0;  // r31 included, no stack pointer preset
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // write-through so a WB result is visible in ID in the same cycle
    assign rd_val = (wr_en && wr_idx == rd_idx) ? wr_data : regs[rd_idx];
    assign rs_val = (wr_en && wr_idx == rs_idx) ? wr_data : regs[rs_idx];
    assign rt_val = (wr_en && wr_idx == rt_idx) ? wr_data : regs[rt_idx];

endmodule

`default_nettype wire

// ==== hw/tinker_decode.sv ====
`default_nettype none

`include "tinker_consts.svh"

module tinker_decode import tinker_pkg::*; (
    input  wire logic [`TINKER_ILEN-1:0] instr,
    input  wire logic [31:0]             pc,
    input  wire logic [`TINKER_XLEN-1:0] rd_val,
    input  wire logic [`TINKER_XLEN-1:0] rs_val,
    input  wire logic [`TINKER_XLEN-1:0] rt_val,
    output idex_t                        fields,
    output logic                         take_branch,
    output logic [31:0]                  branch_target
);
    opcode_e                  op;
    logic [`TINKER_LIT_W-1:0] lit;

    assign op  = opcode_e'(instr[`TINKER_OP_MSB -: 5]);  // unknown codes fall to default
    assign lit = instr[`TINKER_LIT_W-1:0];

    // fields and control, register values are filled in by the core
    always_comb begin
        fields        = '0;
        fields.opcode = op;
        fields.rd     = instr[`TINKER_RD_MSB -: `TINKER_RIDX_W];
        fields.rs     = instr[`TINKER_RS_MSB -: `TINKER_RIDX_W];
        fields.rt     = instr[`TINKER_RT_MSB -: `TINKER_RIDX_W];
        fields.lit    = lit;
        case (op)
            op_add, op_addi, op_sub, op_subi,
            op_and, op_or, op_xor, op_not,
            op_shftr, op_shftri, op_shftl, op_shftli,
            op_mov, op_movl:
                fields.ctrl.reg_write = 1'b1;
            op_load: begin
                fields.ctrl.reg_write = 1'b1;
                fields.ctrl.mem_read  = 1'b1;
            end
            op_store:
                fields.ctrl.mem_write = 1'b1;
            op_br, op_brr_rd, op_brr_l, op_brnz, op_brgt:
                fields.ctrl.is_branch = 1'b1;
            op_halt:
                fields.ctrl.halt = 1'b1;
            default: ;  // fp, mul/div, call/return: nop
        endcase
    end

    // early resolution in ID, one slot squashed by the core
    always_comb begin
        take_branch   = 1'b0;
        branch_target = pc + 32'd4;
        case (op)
            op_br: begin
                take_branch   = 1'b1;
                branch_target = rd_val[31:0];
            end
            op_brr_rd: begin
                take_branch   = 1'b1;
                branch_target = pc + rd_val[31:0];
            end
            op_brr_l: begin
                take_branch   = 1'b1;
                branch_target = pc + {{(32-`TINKER_LIT_W){lit[`TINKER_LIT_W-1]}}, lit};
            end
            op_brnz: begin
                take_branch   = rs_val != '0;
                branch_target = rd_val[31:0];
            end
            op_brgt: begin
                take_branch   = $signed(rs_val) > $signed(rt_val);
                branch_target = rd_val[31:0];
            end
            op_halt: begin
                take_branch   = 1'b1;  // spin on itself
                branch_target = pc;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/tinker_hazard.sv ====
`default_nettype none

`include "tinker_consts.svh"

module tinker_hazard import tinker_pkg::*; (
    input  wire idex_t  id_fields,
    input  wire idex_t  idex,
    input  wire exmem_t exmem,
    input  wire memwb_t memwb,
    output logic        stall,
    output fwd_sel_e    sel_rd,
    output fwd_sel_e    sel_rs,
    output fwd_sel_e    sel_rt
);
    logic load_use;
    logic branch_dep;

    // any of the three fields counts as a read, conservative
    function automatic logic reads(input idex_t f, input logic [`TINKER_RIDX_W-1:0] idx);
        return f.rd == idx || f.rs == idx || f.rt == idx;
    endfunction

    // newest producer wins
    function automatic fwd_sel_e pick(input exmem_t em, input memwb_t mw,
                                      input logic [`TINKER_RIDX_W-1:0] idx);
        if (em.ctrl.reg_write && em.rd == idx)
            return from_exmem;
        if (mw.ctrl.reg_write && mw.rd == idx)
            return from_memwb;
        return from_regfile;
    endfunction

    assign load_use = idex.ctrl.mem_read && reads(id_fields, idex.rd);

    // branch reads regs in ID, only EX/MEM alu results are forwarded there
    assign branch_dep = id_fields.ctrl.is_branch &&
                        ((idex.ctrl.reg_write && reads(id_fields, idex.rd)) ||
                         (exmem.ctrl.mem_read && reads(id_fields, exmem.rd)));

    assign stall = load_use || branch_dep;

    assign sel_rd = pick(exmem, memwb, idex.rd);
    assign sel_rs = pick(exmem, memwb, idex.rs);
    assign sel_rt = pick(exmem, memwb, idex.rt);

    always_comb begin
        assert final (!stall || idex.ctrl.reg_write || exmem.ctrl.reg_write)
            else $error("stall with no register write pending in EX or MEM");
    end

endmodule

`default_nettype wire

// ==== hw/tinker_memory.sv ====
`default_nettype none

`include "tinker_consts.svh"

module tinker_memory import tinker_pkg::*; (
    input  wire logic        clk,
    input  wire logic        reset,
    input  wire apb_req_t    apb_req,
    output apb_rsp_t         apb_rsp,
    input  wire logic        running,
    input  wire logic [31:0] fetch_addr,
    output logic [31:0]      fetch_word,
    input  wire logic [31:0] data_addr,
    output logic [63:0]      load_data,
    input  wire logic        store_en,
    input  wire logic [63:0] store_data,
    output logic             start
);
    localparam int AW = $clog2(`TINKER_MEM_BYTES);

    logic [7:0]    mem [`TINKER_MEM_BYTES];
    logic [AW-1:0] fa, da, pa;
    logic          access, in_mem, ctrl_wr, err, mem_wr;
    logic [31:0]   apb_word;

    assign fa = fetch_addr[AW-1:0];
    assign da = data_addr[AW-1:0];
    assign pa = {apb_req.paddr[AW-1:2], 2'b00};  // host words are 4-aligned

    assign access  = apb_req.psel && apb_req.penable;  // act in the access cycle
    assign in_mem  = apb_req.paddr < `TINKER_MEM_BYTES;
    assign ctrl_wr = apb_req.pwrite && apb_req.paddr == `TINKER_CTRL_ADDR;
    assign err     = access && (in_mem ? running : !ctrl_wr);  // memory is core-owned while running
    assign mem_wr  = access && apb_req.pwrite && in_mem && !err;

    // little-endian, reads are combinational, offsets wrap at the top
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            fetch_word[8*i +: 8] = mem[fa + AW'(i)];
            apb_word[8*i +: 8]   = mem[pa + AW'(i)];
        end
        for (int i = 0; i < 8; i++)
            load_data[8*i +: 8] = mem[da + AW'(i)];
    end

    always_ff @(posedge clk) begin
        if (store_en) begin
            for (int i = 0; i < 8; i++)
                mem[da + AW'(i)] <= store_data[8*i +: 8];
        end
        if (mem_wr) begin
            for (int i = 0; i < 4; i++)
                mem[pa + AW'(i)] <= apb_req.pwdata[8*i +: 8];
        end
    end

    assign apb_rsp.pready  = 1'b1;  // no wait states
    assign apb_rsp.pslverr = err;
    assign apb_rsp.prdata  = (access && !apb_req.pwrite && in_mem && !err) ? apb_word : '0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            start <= 1'b0;
        else
            start <= access && ctrl_wr && apb_req.pwdata[0];  // one cycle wide
    end

    assert property (@(posedge clk) disable iff (reset) apb_req.penable |-> apb_req.psel)
        else $error("apb penable without psel");

endmodule

`default_nettype wire

// ==== hw/tinker_core.sv ====
`default_nettype none

`include "tinker_consts.svh"

module tinker_core import tinker_pkg::*; (
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire apb_req_t apb_req,
    output apb_rsp_t      apb_rsp,
    output logic          hlt
);
    logic                    running, start, stall, take_branch;
    logic [31:0]             pc, ifid_pc, ifid_instr, fetch_word, branch_target;
    logic [`TINKER_XLEN-1:0] rf_rd, rf_rs, rf_rt, id_rd, id_rs, id_rt;
    logic [`TINKER_XLEN-1:0] ex_rd, ex_rs, ex_rt, alu_result, load_data;
    idex_t                   id_fields, idex_next, idex;
    exmem_t                  exmem_next, exmem;
    memwb_t                  memwb_next, memwb;
    fwd_sel_e                sel_rd, sel_rs, sel_rt;

    // EX/MEM alu results into ID, loads excluded since their data is not read yet
    function automatic logic [`TINKER_XLEN-1:0] id_fwd(input exmem_t em,
            input logic [`TINKER_RIDX_W-1:0] idx, input logic [`TINKER_XLEN-1:0] rf);
        return (em.ctrl.reg_write && !em.ctrl.mem_read && em.rd == idx) ? em.alu_result : rf;
    endfunction

    function automatic logic [`TINKER_XLEN-1:0] ex_fwd(input fwd_sel_e sel,
            input logic [`TINKER_XLEN-1:0] rf, em, wb);
        case (sel)
            from_exmem: return em;
            from_memwb: return wb;
            default:    return rf;
        endcase
    endfunction

    tinker_memory i_memory (
        .clk, .reset, .apb_req, .apb_rsp, .running,
        .fetch_addr (pc),
        .fetch_word,
        .data_addr  (exmem.alu_result[31:0]),
        .load_data,
        .store_en   (running && exmem.ctrl.mem_write),
        .store_data (exmem.store_data),
        .start
    );

    tinker_regfile i_regfile (
        .clk, .reset,
        .rd_idx  (id_fields.rd),
        .rs_idx  (id_fields.rs),
        .rt_idx  (id_fields.rt),
        .rd_val  (rf_rd),
        .rs_val  (rf_rs),
        .rt_val  (rf_rt),
        .wr_en   (running && memwb.ctrl.reg_write),  // write on the edge leaving WB
        .wr_idx  (memwb.rd),
        .wr_data (memwb.wb_data)
    );

    assign id_rd = id_fwd(exmem, id_fields.rd, rf_rd);
    assign id_rs = id_fwd(exmem, id_fields.rs, rf_rs);
    assign id_rt = id_fwd(exmem, id_fields.rt, rf_rt);

    tinker_decode i_decode (
        .instr (ifid_instr), .pc (ifid_pc),
        .rd_val (id_rd), .rs_val (id_rs), .rt_val (id_rt),
        .fields (id_fields), .take_branch, .branch_target
    );

    tinker_hazard i_hazard (
        .id_fields, .idex, .exmem, .memwb, .stall, .sel_rd, .sel_rs, .sel_rt
    );

    always_comb begin
        idex_next        = id_fields;
        idex_next.rd_val = id_rd;
        idex_next.rs_val = id_rs;
        idex_next.rt_val = id_rt;
    end

    // EX operand muxes, rd included
    assign ex_rd = ex_fwd(sel_rd, idex.rd_val, exmem.alu_result, memwb.wb_data);
    assign ex_rs = ex_fwd(sel_rs, idex.rs_val, exmem.alu_result, memwb.wb_data);
    assign ex_rt = ex_fwd(sel_rt, idex.rt_val, exmem.alu_result, memwb.wb_data);

    tinker_alu i_alu (
        .opcode (idex.opcode), .rd_val (ex_rd), .rs_val (ex_rs), .rt_val (ex_rt),
        .lit (idex.lit), .result (alu_result)
    );

    assign exmem_next = '{ctrl: idex.ctrl, alu_result: alu_result,
                          store_data: ex_rs, rd: idex.rd};  // store data is rs
    assign memwb_next = '{ctrl: exmem.ctrl, rd: exmem.rd,
                          wb_data: exmem.ctrl.mem_read ? load_data : exmem.alu_result};

    // run control, halt in WB stops everything on the next edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            hlt     <= 1'b0;
        end else if (start) begin
            running <= 1'b1;
            hlt     <= 1'b0;
        end else if (running && memwb.ctrl.halt) begin
            running <= 1'b0;
            hlt     <= 1'b1;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc         <= `TINKER_PC_RESET;
            ifid_pc    <= '0;
            ifid_instr <= `TINKER_NOP_WORD;
            idex       <= '0;
            exmem      <= '0;
            memwb      <= '0;
        end else if (start) begin  // restart from a clean pipe
            pc         <= `TINKER_PC_RESET;
            ifid_pc    <= '0;
            ifid_instr <= `TINKER_NOP_WORD;
            idex       <= '0;
            exmem      <= '0;
            memwb      <= '0;
        end else if (running) begin
            if (!stall) begin  // hold PC and IF/ID on a stall
                pc         <= take_branch ? branch_target : pc + 32'd4;
                ifid_pc    <= pc;
                ifid_instr <= take_branch ? `TINKER_NOP_WORD : fetch_word;  // squash slot
            end
            idex  <= stall ? '0 : idex_next;  // bubble
            exmem <= exmem_next;
            memwb <= memwb_next;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(hlt && running))
        else $error("hlt and running both high");

endmodule

`default_nettype wire

// ==== verification/tb_clock.sv ====
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk   = 1'b0;
        reset = 1'b1;  // held from time zero
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;  // released on an edge
    end

endmodule

`default_nettype wire

// ==== verification/tinker_tb.sv ====
`default_nettype none

`include "tinker_consts.svh"

module tinker_tb import tinker_pkg::*; ();
    localparam int PROG_WORDS = 220;  // all programs, padded one included
    localparam int APB_XFERS  = 500;  // loads, markers, read-back
    localparam int WATCHDOG   = PROG_WORDS * 4 + APB_XFERS * 3 + 64;
    localparam logic [31:0] NOP = `TINKER_NOP_WORD;

    logic     clk, reset, hlt;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    logic [31:0] lfsr = 32'h25119cbc;
    logic [31:0] prog[$];
    logic        pad;  // three NOPs behind every emitted word
    logic [63:0] exp_alu[14];

    tb_clock #(.PERIOD(8), .RESET_CYCLES(8)) i_clock (.clk, .reset);

    tinker_core i_dut (.clk, .reset, .apb_req, .apb_rsp, .hlt);

    task automatic die(input string msg);
        if (msg != "")
            $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    // galois lfsr, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
            r    = {r[62:0], b};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc(input opcode_e op, input int rd, rs, rt,
                                        input logic [11:0] lit);
        return {op, 5'(rd), 5'(rs), 5'(rt), lit};
    endfunction

    task automatic check_val(input string name, input logic [63:0] exp, got);
        assert (got === exp)
        else begin
            $display("Error: %s expected %h got %h", name, exp, got);
            die("");
        end
    endtask

    // one transfer, setup then access, sampled mid access cycle
    task automatic apb_xfer(input logic wr, input logic [31:0] addr, wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic write32(input logic [31:0] addr, data);
        logic [31:0] r;
        logic        e;
        apb_xfer(1'b1, addr, data, r, e);
        if (e)
            die($sformatf("unexpected slave error on write to %h", addr));
    endtask

    task automatic read32(input logic [31:0] addr, output logic [31:0] data);
        logic e;
        apb_xfer(1'b0, addr, 32'h0, data, e);
        if (e)
            die($sformatf("unexpected slave error on read from %h", addr));
    endtask

    task automatic write64(input logic [31:0] addr, input logic [63:0] data);
        write32(addr, data[31:0]);  // little-endian
        write32(addr + 4, data[63:32]);
    endtask

    task automatic read64(input logic [31:0] addr, output logic [63:0] data);
        logic [31:0] lo, hi;
        read32(addr, lo);
        read32(addr + 4, hi);
        data = {hi, lo};
    endtask

    task automatic emit(input logic [31:0] w);
        prog.push_back(w);
        if (pad)
            repeat (3) prog.push_back(NOP);
    endtask

    task automatic load_program();
        foreach (prog[i])
            write32(`TINKER_PC_RESET + 4 * i, prog[i]);
    endtask

    // start, optionally poke memory while busy, then wait for hlt
    task automatic run_program(input logic probe);
        logic [31:0] r;
        logic        e;
        write32(`TINKER_CTRL_ADDR, 32'h1);
        @(negedge clk);
        @(negedge clk);
        if (hlt)
            die("hlt did not clear after start");
        if (probe) begin
            apb_xfer(1'b1, 32'h800, 32'hdead_beef, r, e);
            if (!e)
                die("memory write accepted while the core runs");
        end
        while (!hlt)
            @(negedge clk);
        repeat (12) @(negedge clk);
        if (!hlt)
            die("hlt dropped without a start");
    endtask

    // alu program, results at base, store after halt at base+0xf0
    task automatic build_alu(input logic [11:0] base, input logic [11:0] lits[5]);
        prog.delete();
        emit(enc(op_load, 1, 0, 0, 12'h400));
        emit(enc(op_load, 2, 0, 0, 12'h408));
        emit(enc(op_add, 3, 1, 2, 0));  // load-use on r2
        emit(enc(op_sub, 4, 1, 2, 0));
        emit(enc(op_and, 5, 1, 2, 0));
        emit(enc(op_or, 6, 1, 2, 0));
        emit(enc(op_xor, 7, 1, 2, 0));
        emit(enc(op_not, 8, 1, 0, 0));
        emit(enc(op_shftr, 9, 1, 2, 0));
        emit(enc(op_shftl, 10, 1, 2, 0));
        emit(enc(op_mov, 11, 1, 0, 0));
        emit(enc(op_addi, 11, 0, 0, lits[0]));  // rd forwarded
        emit(enc(op_mov, 12, 1, 0, 0));
        emit(enc(op_subi, 12, 0, 0, lits[1]));
        emit(enc(op_mov, 13, 1, 0, 0));
        emit(enc(op_shftri, 13, 0, 0, lits[2]));
        emit(enc(op_mov, 14, 1, 0, 0));
        emit(enc(op_shftli, 14, 0, 0, lits[3]));
        emit(enc(op_mov, 15, 1, 0, 0));
        emit(enc(op_movl, 15, 0, 0, lits[4]));
        emit(enc(op_mov, 16, 3, 0, 0));
        for (int i = 0; i < 14; i++)
            emit(enc(op_store, 0, 3 + i, 0, base + 12'(8 * i)));
        emit(enc(op_halt, 0, 0, 0, 0));
        emit(enc(op_store, 0, 1, 0, base + 12'hf0));  // never reached
    endtask

    // branch program, index i sits at 0x100 + 4i
    task automatic build_branch();
        prog.delete();
        pad = 1'b0;
        emit(enc(op_xor, 20, 20, 20, 0));
        emit(enc(op_xor, 21, 21, 21, 0));
        emit(enc(op_movl, 21, 0, 0, 12'h5a5));
        emit(enc(op_xor, 22, 22, 22, 0));
        emit(enc(op_movl, 20, 0, 0, 12'h11c));  // idx 7
        emit(enc(op_br, 20, 0, 0, 0));          // idx 5, dependent, stalls
        emit(enc(op_store, 0, 21, 0, 12'h700)); // squash slot
        emit(enc(op_store, 0, 21, 0, 12'h708));
        emit(enc(op_brr_l, 0, 0, 0, 12'd8));
        emit(enc(op_store, 0, 21, 0, 12'h710));
        emit(enc(op_store, 0, 21, 0, 12'h718));
        emit(enc(op_xor, 23, 23, 23, 0));
        emit(enc(op_movl, 23, 0, 0, 12'd8));
        emit(enc(op_brr_rd, 23, 0, 0, 0));      // idx 13 to 15
        emit(enc(op_store, 0, 21, 0, 12'h720));
        emit(enc(op_store, 0, 21, 0, 12'h728));
        emit(enc(op_movl, 20, 0, 0, 12'h14c));
        emit(enc(op_brnz, 20, 22, 0, 0));       // r22 zero, falls through
        emit(enc(op_store, 0, 21, 0, 12'h730));
        emit(enc(op_movl, 20, 0, 0, 12'h158));  // idx 22
        emit(enc(op_brnz, 20, 21, 0, 0));
        emit(enc(op_store, 0, 21, 0, 12'h738));
        emit(enc(op_store, 0, 21, 0, 12'h740));
        emit(enc(op_movl, 20, 0, 0, 12'h100));
        emit(enc(op_brgt, 20, 22, 21, 0));      // 0 > 0x5a5 false
        emit(enc(op_store, 0, 21, 0, 12'h748));
        emit(enc(op_movl, 20, 0, 0, 12'h174));  // idx 29
        emit(enc(op_brgt, 20, 21, 22, 0));
        emit(enc(op_store, 0, 21, 0, 12'h750));
        emit(enc(op_store, 0, 21, 0, 12'h758));
        emit(enc(op_halt, 0, 0, 0, 0));
        emit(enc(op_store, 0, 21, 0, 12'h760));
    endtask

    assert property (@(posedge clk) disable iff (reset) apb_rsp.pready)
        else die("pready went low");
    assert property (@(posedge clk) disable iff (reset) apb_rsp.pslverr |-> apb_rsp.prdata == '0)
        else die("errored transfer returned data");
    assert property (@(posedge clk) disable iff (reset) $fell(hlt) |-> $past(i_dut.start))
        else die("hlt fell without a start pulse");

    initial begin
        #(WATCHDOG * 8);
        die("watchdog timeout, the run did not finish");
    end

    initial begin
        logic [31:0] words[16];
        logic [31:0] r;
        logic        e;
        logic [63:0] a, b, got, other, marker;
        logic [11:0] lits[5];
        logic [31:0] skip[6];
        logic [31:0] hit[7];

        apb_req <= '0;
        pad = 1'b0;
        @(negedge reset);
        @(posedge clk);

        // apb round trip on random words
        foreach (words[i]) begin
            words[i] = 32'(rand_bits(32));
            write32(32'h800 + 4 * i, words[i]);
        end
        foreach (words[i]) begin
            read32(32'h800 + 4 * i, r);
            check_val("prdata", words[i], r);
        end
        apb_xfer(1'b0, 32'h2000, 0, r, e);  // out of range
        if (!e)
            die("no slave error on a read above memory");
        apb_xfer(1'b1, 32'h1804, {~words[1][31:1], 1'b1}, r, e);  // aliases 0x804
        if (!e)
            die("no slave error on a write above the control address");
        read32(32'h804, r);
        check_val("mem[0x804]", {32'h0, words[1]}, {32'h0, r});

        // alu program, operands random
        a = rand_bits(64);
        b = rand_bits(64);
        foreach (lits[i])
            lits[i] = 12'(rand_bits(12));
        write64(32'h400, a);
        write64(32'h408, b);
        exp_alu = '{a + b, a - b, a & b, a | b, a ^ b, ~a, a >> b[5:0], a << b[5:0],
                    a + {52'h0, lits[0]}, a - {52'h0, lits[1]},
                    a >> lits[2][5:0], a << lits[3][5:0], {a[63:12], lits[4]}, a + b};
        marker = rand_bits(64);
        write64(32'h5f0, marker);
        write64(32'h6f0, marker);
        build_alu(12'h500, lits);
        load_program();
        run_program(1'b1);
        read32(32'h800, r);
        check_val("mem[0x800]", {32'h0, words[0]}, {32'h0, r});  // busy write dropped
        for (int i = 0; i < 14; i++) begin
            read64(32'h500 + 8 * i, got);
            check_val($sformatf("alu result %0d", i), exp_alu[i], got);
        end
        read64(32'h5f0, got);
        check_val("post-halt slot", marker, got);

        // same chain padded with nops, second start
        pad = 1'b1;
        build_alu(12'h600, lits);
        pad = 1'b0;
        load_program();
        run_program(1'b0);
        for (int i = 0; i < 14; i++) begin
            read64(32'h500 + 8 * i, other);
            read64(32'h600 + 8 * i, got);
            check_val($sformatf("padded result %0d", i), other, got);
        end
        read64(32'h6f0, got);
        check_val("post-halt slot", marker, got);

        // branches, skipped slots keep their marker
        skip = '{32'h700, 32'h710, 32'h720, 32'h738, 32'h750, 32'h760};
        hit  = '{32'h708, 32'h718, 32'h728, 32'h730, 32'h740, 32'h748, 32'h758};
        foreach (skip[i])
            write64(skip[i], marker);
        foreach (hit[i])
            write64(hit[i], marker);
        build_branch();
        load_program();
        run_program(1'b0);
        foreach (skip[i]) begin
            read64(skip[i], got);
            check_val($sformatf("skipped slot %h", skip[i]), marker, got);
        end
        foreach (hit[i]) begin
            read64(hit[i], got);
            check_val($sformatf("taken slot %h", hit[i]), 64'h5a5, got);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+hw
hw/tinker_pkg.sv
hw/tinker_alu.sv
hw/tinker_regfile.sv
hw/tinker_decode.sv
hw/tinker_hazard.sv
hw/tinker_memory.sv
hw/tinker_core.sv
verification/tb_clock.sv
verification/tinker_tb.sv

// ==== Bender.yml ====
package:
  name: tinker

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/tinker_pkg.sv
      - hw/tinker_alu.sv
      - hw/tinker_regfile.sv
      - hw/tinker_decode.sv
      - hw/tinker_hazard.sv
      - hw/tinker_memory.sv
      - hw/tinker_core.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/tinker_tb.sv
